// ==== src.f ====
+incdir+tests
hw/rv_pkg.sv
hw/rv_pipe_if.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_reg_id_ex.sv
hw/rv_execute.sv
hw/rv_exec_pipe.sv
tests/rv_exec_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute pipeline testbench

VERILATOR ?= verilator
TOP       ?= rv_exec_pipe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tests/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx 'Done: no errors' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/rv_prog_table.svh ====
task automatic load_program();
    // Columns are word, pc, expect writeback, rd, data, expect redirect and target
    // Rows rely on x1 = 5, x2 = -3, x3 = 2 and x19 = 5 while x20 stays 0
    // ALU work with forwarding at distance one and write-through at distance two
    add_row(itype(5, 0, 0, 1, opc_op_imm), 'h100, 1, 1, 'h0000_0005, 0, 0);
    add_row(itype(-3, 0, 0, 2, opc_op_imm), 'h104, 1, 2, 'hffff_fffd, 0, 0);
    add_row(rtype('h00, 2, 1, 0, 3), 'h108, 1, 3, 'h0000_0002, 0, 0);
    add_row(rtype('h20, 1, 3, 0, 4), 'h10c, 1, 4, 'hffff_fffd, 0, 0);
    add_row(rtype('h20, 1, 4, 5, 5), 'h110, 1, 5, 'hffff_ffff, 0, 0);
    add_row(rtype('h00, 1, 4, 5, 6), 'h114, 1, 6, 'h07ff_ffff, 0, 0);
    add_row(rtype('h00, 1, 2, 2, 7), 'h118, 1, 7, 'h0000_0001, 0, 0);
    add_row(rtype('h00, 1, 2, 3, 8), 'h11c, 1, 8, 'h0000_0000, 0, 0);
    add_row(itype('h0f0, 1, 4, 9, opc_op_imm), 'h120, 1, 9, 'h0000_00f5, 0, 0);
    add_row(itype('h03c, 9, 7, 10, opc_op_imm), 'h124, 1, 10, 'h0000_0034, 0, 0);
    add_row(itype(4, 1, 1, 11, opc_op_imm), 'h128, 1, 11, 'h0000_0050, 0, 0);
    add_row(itype('h401, 2, 5, 12, opc_op_imm), 'h12c, 1, 12, 'hffff_fffe, 0, 0);
    add_row(itype(-2, 2, 2, 13, opc_op_imm), 'h130, 1, 13, 'h0000_0001, 0, 0);
    add_row(itype(-1, 1, 3, 14, opc_op_imm), 'h134, 1, 14, 'h0000_0001, 0, 0);
    add_row(utype('h12345, 15, opc_lui), 'h138, 1, 15, 'h1234_5000, 0, 0);
    add_row(utype('h00001, 16, opc_auipc), 'h13c, 1, 16, 'h0000_113c, 0, 0);
    add_row(rtype('h00, 3, 9, 6, 17), 'h140, 1, 17, 'h0000_00f7, 0, 0);
    add_row(rtype('h00, 3, 1, 1, 18), 'h144, 1, 18, 'h0000_0014, 0, 0);
    // x0 write is dropped and x0 still reads as zero
    add_row(itype(7, 1, 0, 0, opc_op_imm), 'h148, 0, 0, 0, 0, 0);
    add_row(rtype('h00, 1, 0, 0, 19), 'h14c, 1, 19, 'h0000_0005, 0, 0);
    add_bubble();
    // Every funct3 both taken and not taken
    // A taken branch kills the slot behind it
    add_row(btype(16, 3, 1, 0), 'h150, 0, 0, 0, 0, 0);
    add_row(btype(12, 3, 1, 1), 'h154, 0, 0, 0, 1, 'h160);
    add_row(itype(1, 0, 0, 20, opc_op_imm), 'h158, 0, 0, 0, 0, 0);
    add_row(btype(8, 1, 2, 4), 'h160, 0, 0, 0, 1, 'h168);
    add_row(itype(2, 0, 0, 20, opc_op_imm), 'h164, 0, 0, 0, 0, 0);
    add_row(btype(8, 1, 2, 5), 'h168, 0, 0, 0, 0, 0);
    add_row(btype(8, 1, 2, 6), 'h16c, 0, 0, 0, 0, 0);
    add_row(btype(-8, 1, 2, 7), 'h170, 0, 0, 0, 1, 'h168);
    add_row(itype(3, 0, 0, 20, opc_op_imm), 'h174, 0, 0, 0, 0, 0);
    add_row(btype(12, 19, 1, 0), 'h168, 0, 0, 0, 1, 'h174);
    add_row(itype(4, 0, 0, 20, opc_op_imm), 'h16c, 0, 0, 0, 0, 0);
    add_row(btype(8, 19, 1, 1), 'h174, 0, 0, 0, 0, 0);
    add_row(btype(8, 2, 1, 4), 'h178, 0, 0, 0, 0, 0);
    add_row(btype(16, 2, 1, 5), 'h17c, 0, 0, 0, 1, 'h18c);
    add_row(itype(5, 0, 0, 20, opc_op_imm), 'h180, 0, 0, 0, 0, 0);
    add_row(btype(8, 2, 1, 6), 'h18c, 0, 0, 0, 1, 'h194);
    add_row(itype(6, 0, 0, 20, opc_op_imm), 'h190, 0, 0, 0, 0, 0);
    add_row(btype(8, 2, 1, 7), 'h194, 0, 0, 0, 0, 0);
    // Jumps link pc + 4 and JALR clears target bit 0
    add_row(jtype('h20, 21), 'h198, 1, 21, 'h0000_019c, 1, 'h1b8);
    add_row(itype(7, 0, 0, 20, opc_op_imm), 'h19c, 0, 0, 0, 0, 0);
    add_row(itype('h065, 21, 0, 22, opc_jalr), 'h1b8, 1, 22, 'h0000_01bc, 1, 'h200);
    add_row(itype(8, 0, 0, 20, opc_op_imm), 'h1bc, 0, 0, 0, 0, 0);
    add_row(itype(4, 22, 0, 23, opc_op_imm), 'h200, 1, 23, 'h0000_01c0, 0, 0);
    add_row(rtype('h00, 1, 20, 0, 24), 'h204, 1, 24, 'h0000_0005, 0, 0);
    add_row(jtype(-8, 0), 'h208, 0, 0, 0, 1, 'h200);
    add_bubble();
endtask

// ==== tests/rv_exec_pipe_tb.sv ====
`timescale 1ns/1ps

module rv_exec_pipe_tb;
    import rv_pkg::*;

    localparam int reset_cycles = 8;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        expect_wb;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        expect_redirect;
        logic [31:0] exp_target;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    entry_t prog [$];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;

    rv_exec_pipe #(.XLEN(32), .ID_EX_REG(1)) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pc             (pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #5 clk = ~clk;

    // Instruction encoders, straight from the RV32I formats
    function automatic logic [31:0] rtype(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
    endfunction

    function automatic logic [31:0] itype(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] btype(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] jtype(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic logic [31:0] utype(int imm, int rd, logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    task automatic add_row(logic [31:0] word, logic [31:0] at_pc, int wb, int rd,
                           logic [31:0] data, int rdr, logic [31:0] tgt);
        entry_t e;
        e.valid           = 1'b1;
        e.instr           = word;
        e.pc              = at_pc;
        e.expect_wb       = (wb != 0);
        e.exp_rd          = rd[4:0];
        e.exp_data        = data;
        e.expect_redirect = (rdr != 0);
        e.exp_target      = tgt;
        prog.push_back(e);
    endtask

    // instr_valid low, nothing expected back
    task automatic add_bubble();
        entry_t e;
        e = '0;
        prog.push_back(e);
    endtask

    `include "rv_prog_table.svh"

    task automatic drive_entry(entry_t e);
        instr_valid = e.valid;
        instr       = e.instr;
        pc          = e.pc;
    endtask

    task automatic check_outputs(int idx, entry_t e);
        checks++;
        if (wb_valid !== e.expect_wb) begin
            errors++;
            $display("** Error at %0t: slot %0d wb_valid %b, expected %b",
                     $time, idx, wb_valid, e.expect_wb);
        end else if (e.expect_wb && (wb_rd !== e.exp_rd || wb_data !== e.exp_data)) begin
            errors++;
            $display("** Error at %0t: slot %0d wrote x%0d = 0x%08h, expected x%0d = 0x%08h",
                     $time, idx, wb_rd, wb_data, e.exp_rd, e.exp_data);
        end
        if (redirect_valid !== e.expect_redirect) begin
            errors++;
            $display("** Error at %0t: slot %0d redirect_valid %b, expected %b",
                     $time, idx, redirect_valid, e.expect_redirect);
        end else if (e.expect_redirect && redirect_pc !== e.exp_target) begin
            errors++;
            $display("** Error at %0t: slot %0d redirect to 0x%08h, expected 0x%08h",
                     $time, idx, redirect_pc, e.exp_target);
        end
    endtask

    // Run limit counts cycles after reset release
    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                $display("Timeout: stimulus did not finish within %0d cycles", cycle_limit);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        entry_t idle;
        idle        = '0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        load_program();
        cycle_limit = prog.size() + 20;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        // Slot i is driven here and shows at the outputs two falling edges later
        for (int i = 0; i < prog.size() + 2; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_outputs(i - 2, prog[i - 2]);
            end else begin
                check_outputs(-1, idle);
            end
            if (i < prog.size()) begin
                drive_entry(prog[i]);
            end else begin
                drive_entry(idle);
            end
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== hw/rv_exec_pipe.sv ====
`timescale 1ns/1ps

module rv_exec_pipe #(
    parameter int XLEN      = rv_pkg::xlen_c,
    parameter int ID_EX_REG = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic [XLEN-1:0]   pc,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output logic [XLEN-1:0]   wb_data,
    output logic              redirect_valid,
    output logic [XLEN-1:0]   redirect_pc
);
    import rv_pkg::*;

    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [XLEN-1:0] rs1_rdata;
    logic [XLEN-1:0] rs2_rdata;
    logic            redirect_now;

    // Decode to ID/EX, and ID/EX to execute
    rv_pipe_if #(.XLEN(XLEN)) id_bus ();
    rv_pipe_if #(.XLEN(XLEN)) ex_bus ();

    rv_regfile #(.XLEN(XLEN)) regfile0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .rs1_data (rs1_rdata),
        .rs2_data (rs2_rdata),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    rv_decode #(.XLEN(XLEN)) decode0 (
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1         (rs1_addr),
        .rs2         (rs2_addr),
        .rs1_data    (rs1_rdata),
        .rs2_data    (rs2_rdata),
        .id_bus      (id_bus.src)
    );

    rv_reg_id_ex #(.XLEN(XLEN), .ID_EX_REG(ID_EX_REG)) reg_id_ex0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect_now (redirect_now),
        .id_bus       (id_bus.dst),
        .ex_bus       (ex_bus.src)
    );

    rv_execute #(.XLEN(XLEN)) execute0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_bus         (ex_bus.dst),
        .redirect_now   (redirect_now),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute #(
    parameter int XLEN = rv_pkg::xlen_c
) (
    input  logic              clk,
    input  logic              rst_n,
    rv_pipe_if.dst            ex_bus,
    output logic              redirect_now,
    output logic              redirect_valid,
    output logic [XLEN-1:0]   redirect_pc,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output logic [XLEN-1:0]   wb_data
);
    import rv_pkg::*;

    localparam int shamt_w = $clog2(XLEN);

    logic [XLEN-1:0]    rs1_val;
    logic [XLEN-1:0]    rs2_val;
    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [shamt_w-1:0] shamt;
    logic [XLEN-1:0]    alu_res;
    logic               branch_cond;
    logic [XLEN-1:0]    target;
    logic [XLEN-1:0]    result;

    // Forward from the slot one older, still in the WB register
    assign rs1_val = (wb_valid && wb_rd != '0 && wb_rd == ex_bus.rs1) ? wb_data : ex_bus.rs1_data;
    assign rs2_val = (wb_valid && wb_rd != '0 && wb_rd == ex_bus.rs2) ? wb_data : ex_bus.rs2_data;

    always_comb begin
        case (ex_bus.alu_a_src)
            a_src_rs1: op_a = rs1_val;
            a_src_pc:  op_a = ex_bus.pc;
            default:   op_a = '0;
        endcase
    end

    assign op_b  = ex_bus.alu_b_imm ? ex_bus.imm : rs2_val;
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (ex_bus.alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sll:  alu_res = op_a << shamt;
            alu_slt:  alu_res = XLEN'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_res = XLEN'(op_a < op_b);
            alu_xor:  alu_res = op_a ^ op_b;
            alu_srl:  alu_res = op_a >> shamt;
            alu_sra:  alu_res = $signed(op_a) >>> shamt;
            alu_or:   alu_res = op_a | op_b;
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_b;
        endcase
    end

    // Branch compare works on forwarded register values
    always_comb begin
        case (ex_bus.funct3)
            3'd0:    branch_cond = rs1_val == rs2_val;
            3'd1:    branch_cond = rs1_val != rs2_val;
            3'd4:    branch_cond = $signed(rs1_val) < $signed(rs2_val);
            3'd5:    branch_cond = $signed(rs1_val) >= $signed(rs2_val);
            3'd6:    branch_cond = rs1_val < rs2_val;
            3'd7:    branch_cond = rs1_val >= rs2_val;
            default: branch_cond = 1'b0;
        endcase
    end

    assign redirect_now = ex_bus.valid && (ex_bus.is_jump || (ex_bus.is_branch && branch_cond));

    // JALR target has bit 0 cleared
    always_comb begin
        if (ex_bus.jb_src == jb_rs1) begin
            target = (rs1_val + ex_bus.imm) & ~XLEN'(1);
        end else begin
            target = ex_bus.pc + ex_bus.imm;
        end
    end

    assign result = (ex_bus.res_src == res_pc_plus4) ? ex_bus.pc_plus4 : alu_res;

    // EX/WB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid       <= 1'b0;
            wb_rd          <= '0;
            wb_data        <= '0;
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            // Writes to x0 are not reported
            wb_valid       <= ex_bus.valid && ex_bus.reg_write && ex_bus.rd != '0;
            wb_rd          <= ex_bus.rd;
            wb_data        <= result;
            redirect_valid <= redirect_now;
            redirect_pc    <= target;
        end
    end

endmodule

// ==== hw/rv_reg_id_ex.sv ====
`timescale 1ns/1ps

module rv_reg_id_ex #(
    parameter int XLEN      = rv_pkg::xlen_c,
    parameter int ID_EX_REG = 1
) (
    input logic    clk,
    input logic    rst_n,
    input logic    redirect_now,
    rv_pipe_if.dst id_bus,
    rv_pipe_if.src ex_bus
);
    import rv_pkg::*;

    if (ID_EX_REG != 0) begin : g_registered
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                ex_bus.valid     <= 1'b0;
                ex_bus.reg_write <= 1'b0;
                ex_bus.alu_a_src <= a_src_rs1;
                ex_bus.alu_b_imm <= 1'b0;
                ex_bus.alu_op    <= alu_add;
                ex_bus.res_src   <= res_alu;
                ex_bus.is_branch <= 1'b0;
                ex_bus.is_jump   <= 1'b0;
                ex_bus.jb_src    <= jb_pc;
                ex_bus.rd        <= '0;
                ex_bus.rs1       <= '0;
                ex_bus.rs2       <= '0;
                ex_bus.funct3    <= '0;
                ex_bus.rs1_data  <= '0;
                ex_bus.rs2_data  <= '0;
                ex_bus.imm       <= '0;
                ex_bus.pc        <= '0;
                ex_bus.pc_plus4  <= '0;
            end else begin
                // A redirect in EX kills the younger slot now in ID
                ex_bus.valid     <= id_bus.valid && !redirect_now;
                ex_bus.reg_write <= id_bus.reg_write;
                ex_bus.alu_a_src <= id_bus.alu_a_src;
                ex_bus.alu_b_imm <= id_bus.alu_b_imm;
                ex_bus.alu_op    <= id_bus.alu_op;
                ex_bus.res_src   <= id_bus.res_src;
                ex_bus.is_branch <= id_bus.is_branch;
                ex_bus.is_jump   <= id_bus.is_jump;
                ex_bus.jb_src    <= id_bus.jb_src;
                ex_bus.rd        <= id_bus.rd;
                ex_bus.rs1       <= id_bus.rs1;
                ex_bus.rs2       <= id_bus.rs2;
                ex_bus.funct3    <= id_bus.funct3;
                ex_bus.rs1_data  <= id_bus.rs1_data;
                ex_bus.rs2_data  <= id_bus.rs2_data;
                ex_bus.imm       <= id_bus.imm;
                ex_bus.pc        <= id_bus.pc;
                ex_bus.pc_plus4  <= id_bus.pc_plus4;
            end
        end
    end else begin : g_passthrough
        assign ex_bus.valid     = id_bus.valid;
        assign ex_bus.reg_write = id_bus.reg_write;
        assign ex_bus.alu_a_src = id_bus.alu_a_src;
        assign ex_bus.alu_b_imm = id_bus.alu_b_imm;
        assign ex_bus.alu_op    = id_bus.alu_op;
        assign ex_bus.res_src   = id_bus.res_src;
        assign ex_bus.is_branch = id_bus.is_branch;
        assign ex_bus.is_jump   = id_bus.is_jump;
        assign ex_bus.jb_src    = id_bus.jb_src;
        assign ex_bus.rd        = id_bus.rd;
        assign ex_bus.rs1       = id_bus.rs1;
        assign ex_bus.rs2       = id_bus.rs2;
        assign ex_bus.funct3    = id_bus.funct3;
        assign ex_bus.rs1_data  = id_bus.rs1_data;
        assign ex_bus.rs2_data  = id_bus.rs2_data;
        assign ex_bus.imm       = id_bus.imm;
        assign ex_bus.pc        = id_bus.pc;
        assign ex_bus.pc_plus4  = id_bus.pc_plus4;
    end

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode #(
    parameter int XLEN = rv_pkg::xlen_c
) (
    input  logic              instr_valid,
    input  rv_pkg::instr_u    instr,
    input  logic [XLEN-1:0]   pc,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   rs2_data,
    rv_pipe_if.src            id_bus
);
    import rv_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    alu_op_e         alu_op_arith;

    // Immediate formats, all sign extended from bit 31
    assign imm_i = XLEN'($signed(instr.i.imm12));
    assign imm_u = XLEN'($signed({instr.r.funct7, instr.r.rs2, instr.r.rs1,
                                  instr.r.funct3, 12'b0}));
    assign imm_b = XLEN'($signed({instr.r.funct7[6], instr.i.rd[0], instr.r.funct7[5:0],
                                  instr.i.rd[4:1], 1'b0}));
    assign imm_j = XLEN'($signed({instr.r.funct7[6], instr.r.rs1, instr.r.funct3,
                                  instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1],
                                  1'b0}));

    // Register file addresses come straight from the word
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    // ALU operation shared by OP and OP-IMM
    always_comb begin
        case (instr.i.funct3)
            3'd0: begin
                // Only OP has sub, OP-IMM bit 30 belongs to the immediate
                if (instr.r.opcode == opc_op && instr.r.funct7[5]) begin
                    alu_op_arith = alu_sub;
                end else begin
                    alu_op_arith = alu_add;
                end
            end
            3'd1: alu_op_arith = alu_sll;
            3'd2: alu_op_arith = alu_slt;
            3'd3: alu_op_arith = alu_sltu;
            3'd4: alu_op_arith = alu_xor;
            3'd5: alu_op_arith = instr.r.funct7[5] ? alu_sra : alu_srl;
            3'd6: alu_op_arith = alu_or;
            default: alu_op_arith = alu_and;
        endcase
    end

    always_comb begin
        id_bus.valid     = instr_valid;
        id_bus.reg_write = 1'b0;
        id_bus.alu_a_src = a_src_rs1;
        id_bus.alu_b_imm = 1'b0;
        id_bus.alu_op    = alu_add;
        id_bus.res_src   = res_alu;
        id_bus.is_branch = 1'b0;
        id_bus.is_jump   = 1'b0;
        id_bus.jb_src    = jb_pc;
        id_bus.imm       = imm_i;

        case (opcode_e'(instr.r.opcode))
            opc_op: begin
                id_bus.reg_write = 1'b1;
                id_bus.alu_op    = alu_op_arith;
            end
            opc_op_imm: begin
                id_bus.reg_write = 1'b1;
                id_bus.alu_b_imm = 1'b1;
                id_bus.alu_op    = alu_op_arith;
            end
            opc_lui: begin
                id_bus.reg_write = 1'b1;
                id_bus.alu_b_imm = 1'b1;
                id_bus.alu_op    = alu_pass_b;
                id_bus.imm       = imm_u;
            end
            opc_auipc: begin
                id_bus.reg_write = 1'b1;
                id_bus.alu_a_src = a_src_pc;
                id_bus.alu_b_imm = 1'b1;
                id_bus.imm       = imm_u;
            end
            opc_jal: begin
                id_bus.reg_write = 1'b1;
                id_bus.res_src   = res_pc_plus4;
                id_bus.is_jump   = 1'b1;
                id_bus.imm       = imm_j;
            end
            opc_jalr: begin
                id_bus.reg_write = 1'b1;
                id_bus.res_src   = res_pc_plus4;
                id_bus.is_jump   = 1'b1;
                id_bus.jb_src    = jb_rs1;
            end
            opc_branch: begin
                id_bus.is_branch = 1'b1;
                id_bus.imm       = imm_b;
            end
            // Unsupported opcodes leave the slot empty
            default: id_bus.valid = 1'b0;
        endcase
    end

    assign id_bus.rd       = instr.i.rd;
    assign id_bus.rs1      = instr.r.rs1;
    assign id_bus.rs2      = instr.r.rs2;
    assign id_bus.funct3   = instr.i.funct3;
    assign id_bus.rs1_data = rs1_data;
    assign id_bus.rs2_data = rs2_data;
    assign id_bus.pc       = pc;
    assign id_bus.pc_plus4 = pc + XLEN'(4);

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
    parameter int XLEN = rv_pkg::xlen_c
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic [XLEN-1:0]   wb_data
);
    import rv_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Newest value wins when writeback hits the same register
    function automatic logic [XLEN-1:0] read_port(reg_addr_t addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_valid && wb_rd == addr) begin
            value = wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

// ==== hw/rv_pipe_if.sv ====
`timescale 1ns/1ps

interface rv_pipe_if #(
    parameter int XLEN = rv_pkg::xlen_c
);
    import rv_pkg::*;

    // Control fields of the slot
    logic       valid;
    logic       reg_write;
    alu_a_src_e alu_a_src;
    logic       alu_b_imm;
    alu_op_e    alu_op;
    res_src_e   res_src;
    logic       is_branch;
    logic       is_jump;
    jb_src_e    jb_src;

    // Register indices and data
    reg_addr_t       rd;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    logic [2:0]      funct3;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;

    modport src (
        output valid, reg_write, alu_a_src, alu_b_imm, alu_op, res_src, is_branch, is_jump,
        output jb_src, rd, rs1, rs2, funct3, rs1_data, rs2_data, imm, pc, pc_plus4
    );

    modport dst (
        input valid, reg_write, alu_a_src, alu_b_imm, alu_op, res_src, is_branch, is_jump,
        input jb_src, rd, rs1, rs2, funct3, rs1_data, rs2_data, imm, pc, pc_plus4
    );

endinterface

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // Default datapath width
    localparam int xlen_c = 32;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        a_src_rs1,
        a_src_pc,
        a_src_zero
    } alu_a_src_e;

    typedef enum logic [1:0] {
        res_alu,
        res_pc_plus4
    } res_src_e;

    // Jump and branch target base
    typedef enum logic {
        jb_pc,
        jb_rs1
    } jb_src_e;

    // One instruction word seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage
